// File: flist.f
hdl/armPkg.sv
hdl/alu.sv
hdl/regFile.sv
hdl/instrDecoder.sv
hdl/condUnit.sv
hdl/datapath.sv
hdl/dataMemory.sv
hdl/armTop.sv
verification/armTb.sv

// File: hdl/alu.sv
/* Shared adder/subtractor and logic ops with NZCV generation. */
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  armPkg::wordT  a,
  input  armPkg::wordT  b,
  input  armPkg::aluOpT aluOp,
  output armPkg::wordT  result,
  output armPkg::flagsT flags
);
  import armPkg::*;

  logic        isSub;
  logic        isArith;
  wordT        condInvB;  // b or ~b for subtract
  logic [32:0] sum;       // Bit 32 is carry out

  assign isSub    = (aluOp == aluSub);
  assign isArith  = (aluOp == aluAdd) || isSub;
  assign condInvB = isSub ? ~b : b;
  assign sum      = {1'b0, a} + {1'b0, condInvB} + {32'd0, isSub};

  always_comb begin
    case (aluOp)
      aluAnd:  result = a & b;
      aluOrr:  result = a | b;
      aluEor:  result = a ^ b;
      default: result = sum[31:0];  // Add, sub
    endcase
  end

  assign flags[3] = result[31];        // N
  assign flags[2] = (result == '0);    // Z
  assign flags[1] = isArith & sum[32]; // C, no borrow on sub
  // V when operands agree in sign and the sum does not
  assign flags[0] = isArith & (a[31] == condInvB[31]) & (sum[31] != a[31]);

endmodule

`default_nettype wire

// File: hdl/armPkg.sv
/* Shared widths, encodings and decoded-control structs for the ARMv4 subset core.
   Every RTL block imports this package. */
`default_nettype none

package armPkg;

  typedef logic [31:0] wordT;     // Data, address and PC word
  typedef logic [31:0] instrT;    // Raw instruction word
  typedef logic [3:0]  regAddrT;  // Register number
  typedef logic [3:0]  flagsT;    // N Z C V, MSB first

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl
  } condT;

  // Major opcode, instr[27:26]
  typedef enum logic [1:0] {
    opDp     = 2'b00,
    opMem    = 2'b01,
    opBranch = 2'b10
  } opT;

  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOrr, aluEor} aluOpT;

  // Immediate forms handled by the extender
  typedef enum logic [1:0] {immImm8, immImm12, immBranch24} immSrcT;

  // Unconditional controls from the decoder
  typedef struct packed {
    logic       readPcBase;  // RA1 forced to R15 (branch base)
    logic       readRdAsRm;  // RA2 takes Rd, STR data
    immSrcT     immSrc;
    logic       aluSrcImm;   // SrcB from immediate
    logic       memToReg;    // Result from data memory
    logic       regW;
    logic       memW;
    logic       pcS;         // Branch or write to R15
    logic       linkW;       // BL link write
    logic       movSel;      // Result is SrcB
    logic [1:0] flagW;       // [1] N,Z  [0] C,V
    aluOpT      aluOp;
  } decodeT;

  // Write enables after the condition check
  typedef struct packed {
    logic regWrite;
    logic memWrite;
    logic pcSrc;
    logic linkWrite;
  } writeEnT;

  localparam regAddrT pcReg    = 4'd15;
  localparam regAddrT linkReg  = 4'd14;
  localparam int      memWords = 64;
  localparam wordT    pcStep   = 32'd4;  // Bytes per instruction

endpackage

`default_nettype wire

// File: hdl/armTop.sv
/* Single-cycle ARMv4 subset core with its data memory; instructions
   arrive on the instr port, one per clock. */
`timescale 1ns/1ns
`default_nettype none

module armTop (
  input  logic          clk,
  input  logic          reset,
  input  armPkg::instrT instr,
  output armPkg::wordT  pc,
  output logic          memWrite,
  output armPkg::wordT  dataAdr,
  output armPkg::wordT  writeData
);
  import armPkg::*;

  decodeT  decode;
  writeEnT writeEn;
  flagsT   aluFlags;
  wordT    readData;

  instrDecoder dec (
    .op     (opT'(instr[27:26])),
    .funct  (instr[25:20]),
    .rd     (regAddrT'(instr[15:12])),
    .decode (decode)
  );

  condUnit cu (
    .clk      (clk),
    .reset    (reset),
    .cond     (condT'(instr[31:28])),
    .aluFlags (aluFlags),
    .decode   (decode),
    .writeEn  (writeEn)
  );

  datapath dp (
    .clk       (clk),
    .reset     (reset),
    .instr     (instr),
    .decode    (decode),
    .writeEn   (writeEn),
    .readData  (readData),
    .aluFlags  (aluFlags),
    .pc        (pc),
    .dataAdr   (dataAdr),
    .writeData (writeData)
  );

  assign memWrite = writeEn.memWrite;  // Conditional store strobe

  dataMemory dmem (
    .clk      (clk),
    .memWrite (writeEn.memWrite),
    .adr      (dataAdr),
    .wd       (writeData),
    .rd       (readData)
  );

endmodule

`default_nettype wire

// File: hdl/condUnit.sv
/* NZCV status register plus condition check; every write enable
   of the core passes through here. */
`timescale 1ns/1ns
`default_nettype none

module condUnit (
  input  logic           clk,
  input  logic           reset,
  input  armPkg::condT   cond,
  input  armPkg::flagsT  aluFlags,
  input  armPkg::decodeT decode,
  output armPkg::writeEnT writeEn
);
  import armPkg::*;

  flagsT      flags;     // Stored N Z C V
  logic       condEx;    // Instruction executes
  logic [1:0] flagWrite;
  logic       n, z, c, v;
  logic       ge;

  assign {n, z, c, v} = flags;
  assign ge = (n == v);

  always_comb begin
    case (cond)
      condEq:  condEx = z;
      condNe:  condEx = !z;
      condCs:  condEx = c;
      condCc:  condEx = !c;
      condMi:  condEx = n;
      condPl:  condEx = !n;
      condVs:  condEx = v;
      condVc:  condEx = !v;
      condHi:  condEx = c & !z;
      condLs:  condEx = !c | z;
      condGe:  condEx = ge;
      condLt:  condEx = !ge;
      condGt:  condEx = !z & ge;
      condLe:  condEx = z | !ge;
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;   // 1111 never executes
    endcase
  end

  assign flagWrite = decode.flagW & {2{condEx}};

  // Two halves with separate enables
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= '0;
    end else begin
      if (flagWrite[1]) flags[3:2] <= aluFlags[3:2];  // N, Z
      if (flagWrite[0]) flags[1:0] <= aluFlags[1:0];  // C, V
    end
  end

  assign writeEn.regWrite  = decode.regW  & condEx;
  assign writeEn.memWrite  = decode.memW  & condEx;
  assign writeEn.pcSrc     = decode.pcS   & condEx;
  assign writeEn.linkWrite = decode.linkW & condEx;

endmodule

`default_nettype wire

// File: hdl/dataMemory.sv
/* Word-wide data RAM, written on the clock edge and read combinationally. */
`timescale 1ns/1ns
`default_nettype none

module dataMemory (
  input  logic         clk,
  input  logic         memWrite,
  input  armPkg::wordT adr,
  input  armPkg::wordT wd,
  output armPkg::wordT rd
);
  import armPkg::*;

  localparam int adrBits = $clog2(memWords);

  wordT ram [memWords];

  // Byte address, word index above bit 1
  always_ff @(posedge clk) begin
    if (memWrite) ram[adr[adrBits+1:2]] <= wd;
  end

  assign rd = ram[adr[adrBits+1:2]];

endmodule

`default_nettype wire

// File: hdl/datapath.sv
/* PC register, immediate extension and operand/result muxing
   around the register file and ALU. */
`timescale 1ns/1ns
`default_nettype none

module datapath (
  input  logic            clk,
  input  logic            reset,
  input  armPkg::instrT   instr,
  input  armPkg::decodeT  decode,
  input  armPkg::writeEnT writeEn,
  input  armPkg::wordT    readData,
  output armPkg::flagsT   aluFlags,
  output armPkg::wordT    pc,
  output armPkg::wordT    dataAdr,
  output armPkg::wordT    writeData
);
  import armPkg::*;

  wordT    pcNext, pcPlus4, pcPlus8;
  wordT    extImm;
  wordT    srcA, srcB, rd2;
  wordT    aluResult, movOrAlu, result;
  flagsT   aluNzcv;   // Raw ALU flags
  regAddrT ra1, ra2;

  // Next PC
  assign pcPlus4 = pc + pcStep;
  assign pcPlus8 = pcPlus4 + pcStep;  // Architectural R15
  assign pcNext  = writeEn.pcSrc ? result : pcPlus4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) pc <= '0;
    else       pc <= pcNext;
  end

  // Register reads
  assign ra1 = decode.readPcBase ? pcReg : regAddrT'(instr[19:16]);
  assign ra2 = decode.readRdAsRm ? regAddrT'(instr[15:12]) : regAddrT'(instr[3:0]);

  regFile rf (
    .clk       (clk),
    .regWrite  (writeEn.regWrite),
    .linkWrite (writeEn.linkWrite),
    .ra1       (ra1),
    .ra2       (ra2),
    .wa3       (regAddrT'(instr[15:12])),
    .wd3       (result),
    .linkData  (pcPlus4),           // BL returns to next instruction
    .r15       (pcPlus8),
    .rd1       (srcA),
    .rd2       (rd2)
  );

  always_comb begin
    case (decode.immSrc)
      immImm8:     extImm = {24'd0, instr[7:0]};
      immImm12:    extImm = {20'd0, instr[11:0]};
      immBranch24: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};  // Word offset
      default:     extImm = '0;
    endcase
  end

  assign srcB = decode.aluSrcImm ? extImm : rd2;

  alu alu0 (
    .a      (srcA),
    .b      (srcB),
    .aluOp  (decode.aluOp),
    .result (aluResult),
    .flags  (aluNzcv)
  );

  // MOV takes N and Z from the moved operand
  assign aluFlags  = decode.movSel ? {srcB[31], srcB == '0, aluNzcv[1:0]} : aluNzcv;

  assign movOrAlu  = decode.movSel ? srcB : aluResult;
  assign result    = decode.memToReg ? readData : movOrAlu;
  assign dataAdr   = aluResult;
  assign writeData = rd2;           // STR data, Rd via port 2

endmodule

`default_nettype wire

// File: hdl/instrDecoder.sv
/* Main and ALU decoder; turns opcode, funct and Rd into controls
   that the condition unit later gates. */
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
  input  armPkg::opT      op,
  input  logic [5:0]      funct,
  input  armPkg::regAddrT rd,
  output armPkg::decodeT  decode
);
  import armPkg::*;

  logic isBranch;  // B or BL
  logic isDp;      // Data processing, ALU decoder active
  logic isArith;   // ADD, SUB, CMP touch C and V

  always_comb begin
    decode   = '0;
    isBranch = 1'b0;
    isDp     = 1'b0;
    isArith  = 1'b0;

    // Main decoder
    case (op)
      opDp: begin
        isDp             = 1'b1;
        decode.immSrc    = immImm8;
        decode.aluSrcImm = funct[5];  // I bit
        // CMP (1010) and TST (1000) only set flags
        decode.regW      = !(funct[4:1] == 4'b1010 || funct[4:1] == 4'b1000);
      end
      opMem: begin
        decode.immSrc     = immImm12;
        decode.aluSrcImm  = 1'b1;      // Base plus offset
        decode.memToReg   = funct[0];  // L bit
        decode.regW       = funct[0];  // LDR
        decode.memW       = !funct[0]; // STR
        decode.readRdAsRm = !funct[0]; // Store data from Rd
      end
      opBranch: begin
        isBranch          = 1'b1;
        decode.readPcBase = 1'b1;      // Target relative to PC+8
        decode.immSrc     = immBranch24;
        decode.aluSrcImm  = 1'b1;
        decode.linkW      = funct[4];  // L bit, BL
      end
      default: ;                       // Unsupported, no writes
    endcase

    // ALU decoder
    decode.aluOp = aluAdd;             // Address and branch target sums
    if (isDp) begin
      case (funct[4:1])
        4'b0100: begin
          decode.aluOp = aluAdd;       // ADD
          isArith      = 1'b1;
        end
        4'b0010, 4'b1010: begin
          decode.aluOp = aluSub;       // SUB, CMP
          isArith      = 1'b1;
        end
        4'b0000, 4'b1000: decode.aluOp = aluAnd;  // AND, TST
        4'b1100: decode.aluOp = aluOrr;
        4'b0001: decode.aluOp = aluEor;
        4'b1101: decode.movSel = 1'b1; // MOV passes SrcB
        default: decode.aluOp = aluAdd;
      endcase
      decode.flagW[1] = funct[0];             // S bit
      decode.flagW[0] = funct[0] & isArith;   // Logic ops leave C,V
    end

    // Any taken write to R15 redirects fetch
    decode.pcS = isBranch | (decode.regW & (rd == pcReg));
  end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
/* Fifteen general registers, two combinational reads and one edge write;
   R15 reads come from the PC path. */
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  logic            clk,
  input  logic            regWrite,
  input  logic            linkWrite,
  input  armPkg::regAddrT ra1,
  input  armPkg::regAddrT ra2,
  input  armPkg::regAddrT wa3,
  input  armPkg::wordT    wd3,
  input  armPkg::wordT    linkData,
  input  armPkg::wordT    r15,
  output armPkg::wordT    rd1,
  output armPkg::wordT    rd2
);
  import armPkg::*;

  wordT regs [15];  // R0..R14

  always_ff @(posedge clk) begin
    if (regWrite && wa3 != pcReg) regs[wa3] <= wd3;  // R15 write is a jump
    if (linkWrite) regs[linkReg] <= linkData;         // BL return address
  end

  assign rd1 = (ra1 == pcReg) ? r15 : regs[ra1];
  assign rd2 = (ra2 == pcReg) ? r15 : regs[ra2];

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail

verilator --binary --timing -f flist.f --top-module armTb -o armSim
./obj_dir/armSim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

// File: verification/armTb.sv
/* Directed testbench for armTop; feeds one instruction per clock on instr and checks pc
   and the store port against a reference model of registers, flags, memory and PC. */
`timescale 1ns/1ns
`default_nettype none

module armTb;

  localparam int periodNs    = 4;
  localparam int instrBudget = 400;  // Well above the ~250 instructions issued
  localparam int timeoutNs   = (instrBudget + 4) * periodNs + 100;

  // Data-processing opcodes, instr[24:21]
  localparam logic [3:0] ocAnd = 4'b0000;
  localparam logic [3:0] ocEor = 4'b0001;
  localparam logic [3:0] ocSub = 4'b0010;
  localparam logic [3:0] ocAdd = 4'b0100;
  localparam logic [3:0] ocTst = 4'b1000;
  localparam logic [3:0] ocCmp = 4'b1010;
  localparam logic [3:0] ocOrr = 4'b1100;
  localparam logic [3:0] ocMov = 4'b1101;
  localparam logic [3:0] al    = 4'hE;
  localparam logic [31:0] nvNop = 32'hF000_0000;  // Cond 1111, never executes

  logic        clk;
  logic        reset;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        memWrite;
  logic [31:0] dataAdr;
  logic [31:0] writeData;

  // Reference model state
  logic [31:0] regs [16];
  logic [31:0] memM [64];
  logic [3:0]  flagsM;      // N Z C V
  logic [31:0] pcM;
  logic [31:0] seed;
  int          errors;
  int          checks;

  armTop uut (
    .clk       (clk),
    .reset     (reset),
    .instr     (instr),
    .pc        (pc),
    .memWrite  (memWrite),
    .dataAdr   (dataAdr),
    .writeData (writeData)
  );

  always #(periodNs / 2) clk = ~clk;

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;  // LCG step
    return seed;
  endfunction

  function automatic logic [31:0] dpReg(input logic [3:0] cond, input logic [3:0] opc,
      input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rm);
    return {cond, 3'b000, opc, s, rn, rd, 8'd0, rm};
  endfunction

  function automatic logic [31:0] dpImm(input logic [3:0] cond, input logic [3:0] opc,
      input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [7:0] imm);
    return {cond, 3'b001, opc, s, rn, rd, 4'd0, imm};
  endfunction

  // Word LDR/STR, pre-indexed with positive offset, no writeback
  function automatic logic [31:0] memOp(input logic [3:0] cond, input logic load,
      input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] off);
    return {cond, 2'b01, 4'b0110, 1'b0, load, rn, rd, off};
  endfunction

  function automatic logic [31:0] branch(input logic [3:0] cond, input logic link,
      input logic [23:0] off);
    return {cond, 3'b101, link, off};
  endfunction

  // ARM condition table; odd codes invert the even one below them
  function automatic logic condPasses(input logic [3:0] cond, input logic [3:0] f);
    logic n, z, c, v;
    logic base;
    {n, z, c, v} = f;
    case (cond[3:1])
      3'd0:    base = z;
      3'd1:    base = c;
      3'd2:    base = n;
      3'd3:    base = v;
      3'd4:    base = c && !z;
      3'd5:    base = (n == v);
      3'd6:    base = !z && (n == v);
      default: base = 1'b1;
    endcase
    if (cond == 4'hF) return 1'b0;
    if (cond == al) return 1'b1;
    return base ^ cond[0];
  endfunction

  function automatic logic [31:0] readReg(input logic [3:0] r);
    return (r == 4'd15) ? pcM + 32'd8 : regs[r];  // R15 reads PC+8
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s = %h, expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  // Issue one instruction, check pc and store port, then advance the model
  task automatic runInstr(input logic [31:0] i);
    logic [31:0] a, b, res, adr, nextPc, expData;
    logic [32:0] wide;
    logic [3:0]  opc;
    logic        ex, c, v, expMemW;
    @(posedge clk);
    reset <= 1'b0;
    instr <= i;
    @(negedge clk);
    compare("pc", pc, pcM);
    ex      = condPasses(i[31:28], flagsM);
    expMemW = 1'b0;
    expData = '0;
    adr     = '0;
    nextPc  = pcM + 32'd4;
    case (i[27:26])
      2'b00: begin
        opc = i[24:21];
        a   = readReg(i[19:16]);
        b   = i[25] ? {24'd0, i[7:0]} : readReg(i[3:0]);
        c   = flagsM[1];  // Logic ops keep C, V
        v   = flagsM[0];
        case (opc)
          ocAdd: begin
            wide = {1'b0, a} + {1'b0, b};
            res  = wide[31:0];
            c    = wide[32];
            v    = (a[31] == b[31]) && (res[31] != a[31]);
          end
          ocSub, ocCmp: begin
            wide = {1'b0, a} - {1'b0, b};
            res  = wide[31:0];
            c    = !wide[32];  // Carry means no borrow
            v    = (a[31] != b[31]) && (res[31] != a[31]);
          end
          ocAnd, ocTst: res = a & b;
          ocOrr:        res = a | b;
          ocEor:        res = a ^ b;
          default:      res = b;  // MOV
        endcase
        if (ex) begin
          if (i[20]) flagsM = {res[31], res == 32'd0, c, v};
          if (opc != ocCmp && opc != ocTst) begin
            if (i[15:12] == 4'd15) nextPc = res;  // Jump
            else regs[i[15:12]] = res;
          end
        end
      end
      2'b01: begin
        adr = readReg(i[19:16]) + {20'd0, i[11:0]};
        if (i[20]) begin
          if (ex) regs[i[15:12]] = memM[adr[7:2]];
        end else begin
          expMemW = ex;
          expData = readReg(i[15:12]);
          if (ex) memM[adr[7:2]] = expData;
        end
      end
      2'b10: begin
        if (ex) begin
          nextPc = pcM + 32'd8 + {{6{i[23]}}, i[23:0], 2'b00};
          if (i[24]) regs[14] = pcM + 32'd4;  // Link is the next instruction
        end
      end
      default: ;
    endcase
    compare("memWrite", {31'd0, memWrite}, {31'd0, expMemW});
    if (expMemW) begin
      compare("dataAdr", dataAdr, adr);
      compare("writeData", writeData, expData);
    end
    pcM = nextPc;
  endtask

  task automatic resetFetch();
    @(negedge clk);
    compare("pc", pc, 32'd0);  // Held at 0 under reset
    runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd0, 8'd0));  // R0 = 0, store base
    runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd1, 8'd1));
    runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd2, 8'd2));
  endtask

  task automatic dataProc();
    logic [31:0] r;
    logic [3:0]  ops [5];
    logic [11:0] off;
    ops = '{ocAdd, ocSub, ocAnd, ocOrr, ocEor};
    off = 12'd0;
    r = nextRand();
    runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd1, r[7:0]));
    runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd2, r[15:8]));
    for (int j = 0; j < 5; j++) begin
      r = nextRand();
      runInstr(dpReg(al, ops[j], 1'b0, 4'd1, 4'd3, 4'd2));   // Register form
      runInstr(memOp(al, 1'b0, 4'd0, 4'd3, off));
      runInstr(dpImm(al, ops[j], 1'b0, 4'd1, 4'd4, r[7:0])); // Immediate form
      runInstr(memOp(al, 1'b0, 4'd0, 4'd4, off + 12'd4));
      off = off + 12'd8;
    end
  endtask

  task automatic memRoundTrip();
    logic [31:0] r;
    r = nextRand();
    runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd5, r[7:0]));
    runInstr(memOp(al, 1'b0, 4'd0, 4'd5, 12'h080));
    runInstr(memOp(al, 1'b1, 4'd0, 4'd6, 12'h080));  // LDR, memWrite must stay low
    runInstr(memOp(al, 1'b0, 4'd0, 4'd6, 12'h084));  // Must carry R5's value
  endtask

  // One conditional STR per condition code
  task automatic sweepConds();
    logic [3:0] cc;
    for (int k = 0; k < 15; k++) begin
      cc = 4'(k);
      runInstr(memOp(cc, 1'b0, 4'd0, 4'd1, {6'd0, cc, 2'b00}));
    end
  endtask

  task automatic flagConditions();
    logic [31:0] r;
    runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd1, 8'd5));
    runInstr(dpImm(al, ocCmp, 1'b1, 4'd1, 4'd0, 8'd5));  // Equal
    sweepConds();
    runInstr(dpImm(al, ocSub, 1'b0, 4'd0, 4'd7, 8'd1));  // R7 = all ones
    runInstr(dpImm(al, ocAdd, 1'b1, 4'd7, 4'd8, 8'd2));  // Carry out
    sweepConds();
    runInstr(dpImm(al, ocSub, 1'b1, 4'd0, 4'd8, 8'd3));  // Negative with borrow
    sweepConds();
    runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd9, 8'd1));
    repeat (31) runInstr(dpReg(al, ocAdd, 1'b0, 4'd9, 4'd9, 4'd9));  // R9 = 0x80000000
    runInstr(dpImm(al, ocSub, 1'b1, 4'd9, 4'd10, 8'd1)); // Signed overflow
    sweepConds();
    runInstr(dpReg(al, ocAdd, 1'b1, 4'd9, 4'd10, 4'd9)); // Zero, carry and overflow
    sweepConds();
    runInstr(dpImm(al, ocTst, 1'b1, 4'd7, 4'd0, 8'h80)); // N,Z only
    sweepConds();
    runInstr(dpImm(al, ocAdd, 1'b0, 4'd7, 4'd8, 8'd2));  // No S, flags kept
    sweepConds();
    runInstr(dpImm(al, ocMov, 1'b1, 4'd1, 4'd11, 8'd0)); // Moved zero sets Z despite Rn field
    sweepConds();
    repeat (3) begin
      r = nextRand();
      runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd1, r[7:0]));
      runInstr(dpImm(al, ocCmp, 1'b1, 4'd1, 4'd0, r[15:8]));
      sweepConds();
    end
  endtask

  task automatic branching();
    logic [31:0] r;
    r = nextRand();
    runInstr(branch(al, 1'b0, {20'd0, r[3:0]}));       // Forward
    runInstr(branch(al, 1'b0, 24'hFFFFFC));            // Backward by 4 words
    runInstr(dpImm(al, ocCmp, 1'b1, 4'd0, 4'd0, 8'd1)); // Z cleared
    runInstr(branch(4'h0, 1'b0, 24'd5));               // BEQ, not taken
    runInstr(branch(4'h1, 1'b0, 24'd5));               // BNE, taken
    runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd15, 8'h80)); // Jump via R15
    runInstr(dpImm(al, ocMov, 1'b0, 4'd0, 4'd1, 8'd3));
  endtask

  task automatic linkCheck();
    runInstr(branch(al, 1'b1, 24'd3));
    runInstr(memOp(al, 1'b0, 4'd0, 4'd14, 12'h090));  // Exposes R14
  endtask

  initial begin
    clk    = 1'b0;
    reset  = 1'b1;
    instr  = nvNop;
    seed   = 32'ha885;
    flagsM = 4'd0;
    pcM    = 32'd0;
    errors = 0;
    checks = 0;
    for (int k = 0; k < 16; k++) regs[k] = 32'd0;
    for (int k = 0; k < 64; k++) memM[k] = 32'd0;
    repeat (3) @(posedge clk);  // Fourth edge comes with the first instruction
    resetFetch();
    dataProc();
    memRoundTrip();
    flagConditions();
    branching();
    linkCheck();
    runInstr(nvNop);  // Checks the last PC update
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(timeoutNs);
    $display("Timeout: tests did not finish within %0d ns", timeoutNs);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
